// ==== include/router_defs.svh ====
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// ========================================
// Router geometry
// ========================================
`define NUM_PORTS     5
`define FIFO_DEPTH    4   // Flits per input FIFO.

`define DATA_WIDTH    32  // Payload word.
`define PKT_LEN_WIDTH 4
`define COORD_WIDTH   2

`define ROUTER_X      1   // Position of this router in the mesh.
`define ROUTER_Y      1

// ========================================
// Port indices
// ========================================
`define PORT_LOCAL    0
`define PORT_NORTH    1
`define PORT_SOUTH    2
`define PORT_EAST     3
`define PORT_WEST     4

`endif

// ==== hw/router_pkg.sv ====
`include "router_defs.svh"

package router_pkg;

    // ========================================
    // Flit format
    // ========================================
    typedef struct packed {
        logic [`COORD_WIDTH-1:0]   dest_x;
        logic [`COORD_WIDTH-1:0]   dest_y;
        logic [`PKT_LEN_WIDTH-1:0] pkt_len; // Flits in packet, head included.
        logic [`DATA_WIDTH-2*`COORD_WIDTH-`PKT_LEN_WIDTH-1:0] spare;
    } head_fields_t;

    // Head view is valid only when the head bit is set.
    typedef union packed {
        head_fields_t            head;
        logic [`DATA_WIDTH-1:0]  data;
    } flit_payload_u;

    typedef struct packed {
        logic          head;
        logic          tail;
        flit_payload_u payload;
    } flit_t;

    // ========================================
    // Allocation handshakes
    // ========================================
    typedef logic [2:0] port_sel_t;

    typedef struct packed {
        logic      req_route;
        logic      req_switch;
        logic      req_xbar;
        port_sel_t switch_outport;
    } unit_req_t;

    typedef struct packed {
        logic [`NUM_PORTS-1:0] granted; // One-hot.
        port_sel_t             outport;
    } route_grant_t;

endpackage

// ==== hw/flit_fifo.sv ====
`timescale 1ns/1ps

`include "router_defs.svh"

module flit_fifo #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         wen,
    input  logic                         ren,
    input  router_pkg::flit_t            wdata,
    output router_pkg::flit_t            rdata,
    output logic                         full,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    router_pkg::flit_t mem [DEPTH];
    logic [PTR_W-1:0] wptr, rptr;
    logic do_write, do_read;

    assign full     = count == CNT_W'(DEPTH);
    assign empty    = count == '0;
    assign do_write = wen && !full;  // Drop writes when full.
    assign do_read  = ren && !empty;
    assign rdata    = mem[rptr];     // Show-ahead front flit.

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (do_read) begin
                rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (do_write) begin
            mem[wptr] <= wdata;
        end
    end
endmodule

// ==== hw/input_unit.sv ====
`timescale 1ns/1ps

`include "router_defs.svh"

module input_unit (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  wen,
    input  router_pkg::flit_t     wdata,
    output logic                  full,
    output router_pkg::unit_req_t req,
    output router_pkg::flit_t     head_flit,
    input  logic                  route_granted,
    input  router_pkg::port_sel_t route_outport,
    input  logic                  switch_grant,
    input  logic                  xbar_ren,
    output router_pkg::flit_t     xbar_flit
);
    typedef enum logic [1:0] {
        IDLE,
        ROUTING,
        SWITCH_ALLOCATION,
        ACTIVE
    } state_t;

    typedef struct packed {
        state_t                state;
        router_pkg::port_sel_t outport;
    } state_table_t;

    state_table_t table_q, table_d;
    logic [`PKT_LEN_WIDTH-1:0] pkt_len_q, pkt_len_d;
    logic [`PKT_LEN_WIDTH-1:0] pop_cnt_q, pop_cnt_d;
    logic [$clog2(`FIFO_DEPTH+1)-1:0] fifo_count;
    logic fifo_empty;
    logic pop;
    router_pkg::flit_t front;

    // ========================================
    // Flit buffer
    // ========================================
    flit_fifo #(
        .DEPTH(`FIFO_DEPTH)
    ) fifo (
        .CLK(CLK),
        .nRST(nRST),
        .wen(wen),
        .ren(pop),
        .wdata(wdata),
        .rdata(front),
        .full(full),
        .empty(fifo_empty),
        .count(fifo_count)
    );

    assign pop       = xbar_ren && req.req_xbar && !fifo_empty;
    assign head_flit = front;
    assign xbar_flit = front;

    assign req.req_route      = table_q.state == ROUTING;
    assign req.req_switch     = table_q.state == SWITCH_ALLOCATION;
    assign req.req_xbar       = (table_q.state == ACTIVE) && !fifo_empty; // Starved stays quiet.
    assign req.switch_outport = table_q.outport;

    // ========================================
    // Packet state table
    // ========================================
    always_comb begin
        table_d   = table_q;
        pkt_len_d = pkt_len_q;
        pop_cnt_d = pop_cnt_q;
        case (table_q.state)
            IDLE: begin
                if (wen || fifo_count != '0) begin
                    table_d.state = ROUTING;  // Head arriving or waiting.
                end
            end
            ROUTING: begin
                if (route_granted) begin
                    table_d.outport = route_outport;
                    table_d.state   = SWITCH_ALLOCATION;
                end
            end
            SWITCH_ALLOCATION: begin
                if (switch_grant) begin
                    pkt_len_d     = front.payload.head.pkt_len;
                    pop_cnt_d     = '0;
                    table_d.state = ACTIVE;
                end
            end
            ACTIVE: begin
                if (pop) begin
                    if (pop_cnt_q + 1'b1 == pkt_len_q) begin
                        table_d.state   = IDLE;  // Last flit gone.
                        table_d.outport = '0;
                        pop_cnt_d       = '0;
                    end else begin
                        pop_cnt_d = pop_cnt_q + 1'b1;
                    end
                end
            end
            default: table_d.state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            table_q   <= '{state: IDLE, outport: '0};
            pkt_len_q <= '0;
            pop_cnt_q <= '0;
        end else begin
            table_q   <= table_d;
            pkt_len_q <= pkt_len_d;
            pop_cnt_q <= pop_cnt_d;
        end
    end
endmodule

// ==== hw/route_unit.sv ====
`timescale 1ns/1ps

`include "router_defs.svh"

module route_unit (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  router_pkg::unit_req_t [`NUM_PORTS-1:0]      reqs,
    input  router_pkg::flit_t     [`NUM_PORTS-1:0]      heads,
    output router_pkg::route_grant_t                    grant
);
    localparam logic [`COORD_WIDTH-1:0] MY_X = `ROUTER_X;
    localparam logic [`COORD_WIDTH-1:0] MY_Y = `ROUTER_Y;
    localparam router_pkg::port_sel_t LAST = router_pkg::port_sel_t'(`NUM_PORTS - 1);

    router_pkg::port_sel_t rr_ptr;
    router_pkg::port_sel_t sel;
    router_pkg::head_fields_t hf;
    logic found;

    // Round-robin pick starting at the pointer.
    always_comb begin
        int idx;
        idx   = 0;
        found = 1'b0;
        sel   = '0;
        for (int k = 0; k < `NUM_PORTS; k++) begin
            idx = int'(rr_ptr) + k;
            if (idx >= `NUM_PORTS) begin
                idx = idx - `NUM_PORTS;
            end
            if (!found && reqs[idx].req_route) begin
                found = 1'b1;
                sel   = router_pkg::port_sel_t'(idx);
            end
        end
    end

    // XY routing, X first.
    always_comb begin
        hf = heads[sel].payload.head;
        grant.granted      = '0;
        grant.granted[sel] = found;
        if (hf.dest_x > MY_X) begin
            grant.outport = router_pkg::port_sel_t'(`PORT_EAST);
        end else if (hf.dest_x < MY_X) begin
            grant.outport = router_pkg::port_sel_t'(`PORT_WEST);
        end else if (hf.dest_y > MY_Y) begin
            grant.outport = router_pkg::port_sel_t'(`PORT_NORTH);
        end else if (hf.dest_y < MY_Y) begin
            grant.outport = router_pkg::port_sel_t'(`PORT_SOUTH);
        end else begin
            grant.outport = router_pkg::port_sel_t'(`PORT_LOCAL);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rr_ptr <= '0;
        end else if (found) begin
            rr_ptr <= (sel == LAST) ? '0 : sel + 1'b1;  // Skip past winner.
        end
    end
endmodule

// ==== hw/switch_unit.sv ====
`timescale 1ns/1ps

`include "router_defs.svh"

module switch_unit (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  router_pkg::unit_req_t [`NUM_PORTS-1:0]      reqs,
    input  router_pkg::flit_t     [`NUM_PORTS-1:0]      xbar_flits,
    output logic                  [`NUM_PORTS-1:0]      switch_grant,
    output logic                  [`NUM_PORTS-1:0]      xbar_ren,
    output logic                  [`NUM_PORTS-1:0]      out_valid,
    output router_pkg::flit_t     [`NUM_PORTS-1:0]      out_flit
);
    localparam router_pkg::port_sel_t LAST = router_pkg::port_sel_t'(`NUM_PORTS - 1);

    typedef struct packed {
        logic                      lock;
        router_pkg::port_sel_t     owner;
        router_pkg::port_sel_t     rr_ptr;
        logic [`PKT_LEN_WIDTH-1:0] sent;   // Flits already forwarded.
        logic [`PKT_LEN_WIDTH-1:0] len;
    } out_state_t;

    out_state_t [`NUM_PORTS-1:0] ost_q, ost_d;
    logic [`NUM_PORTS-1:0] pop;
    router_pkg::flit_t [`NUM_PORTS-1:0] sel_flit;

    // ========================================
    // Allocation and crossbar select
    // ========================================
    always_comb begin
        int idx;
        logic found;
        logic [`PKT_LEN_WIDTH-1:0] len_now;
        idx          = 0;
        found        = 1'b0;
        len_now      = '0;
        ost_d        = ost_q;
        switch_grant = '0;
        xbar_ren     = '0;
        pop          = '0;
        for (int o = 0; o < `NUM_PORTS; o++) begin
            sel_flit[o] = xbar_flits[ost_q[o].owner];
            if (ost_q[o].lock) begin
                if (reqs[ost_q[o].owner].req_xbar) begin
                    xbar_ren[ost_q[o].owner] = 1'b1;
                    pop[o] = 1'b1;
                    // First flit is the head and carries the length.
                    len_now = (ost_q[o].sent == '0) ? sel_flit[o].payload.head.pkt_len
                                                    : ost_q[o].len;
                    ost_d[o].len = len_now;
                    if (ost_q[o].sent + 1'b1 == len_now) begin
                        ost_d[o].lock = 1'b0;
                        ost_d[o].sent = '0;
                    end else begin
                        ost_d[o].sent = ost_q[o].sent + 1'b1;
                    end
                end
            end else begin
                found = 1'b0;
                for (int k = 0; k < `NUM_PORTS; k++) begin
                    idx = int'(ost_q[o].rr_ptr) + k;
                    if (idx >= `NUM_PORTS) begin
                        idx = idx - `NUM_PORTS;
                    end
                    if (!found && reqs[idx].req_switch &&
                        reqs[idx].switch_outport == router_pkg::port_sel_t'(o)) begin
                        found             = 1'b1;
                        switch_grant[idx] = 1'b1;
                        ost_d[o].lock     = 1'b1;
                        ost_d[o].owner    = router_pkg::port_sel_t'(idx);
                        ost_d[o].sent     = '0;
                        ost_d[o].rr_ptr   = (router_pkg::port_sel_t'(idx) == LAST) ?
                                            '0 : router_pkg::port_sel_t'(idx + 1);
                    end
                end
            end
        end
    end

    // ========================================
    // Output registers
    // ========================================
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ost_q     <= '0;
            out_valid <= '0;
        end else begin
            ost_q     <= ost_d;
            out_valid <= pop;  // Idle cycle when owner is starved.
        end
    end

    always_ff @(posedge CLK) begin
        for (int o = 0; o < `NUM_PORTS; o++) begin
            if (pop[o]) begin
                out_flit[o] <= sel_flit[o];
            end
        end
    end
endmodule

// ==== hw/router_top.sv ====
`timescale 1ns/1ps

`include "router_defs.svh"

module router_top (
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic              [`NUM_PORTS-1:0]  in_wen,
    input  router_pkg::flit_t [`NUM_PORTS-1:0]  in_flit,
    output logic              [`NUM_PORTS-1:0]  in_full,
    output logic              [`NUM_PORTS-1:0]  out_valid,
    output router_pkg::flit_t [`NUM_PORTS-1:0]  out_flit
);
    router_pkg::unit_req_t [`NUM_PORTS-1:0] reqs;
    router_pkg::flit_t     [`NUM_PORTS-1:0] heads;
    router_pkg::flit_t     [`NUM_PORTS-1:0] xbar_flits;
    router_pkg::route_grant_t route_grant;
    logic [`NUM_PORTS-1:0] switch_grant;
    logic [`NUM_PORTS-1:0] xbar_ren;

    route_unit route (
        .CLK(CLK),
        .nRST(nRST),
        .reqs(reqs),
        .heads(heads),
        .grant(route_grant)
    );

    // One input unit per port.
    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_input
        input_unit unit (
            .CLK(CLK),
            .nRST(nRST),
            .wen(in_wen[i]),
            .wdata(in_flit[i]),
            .full(in_full[i]),
            .req(reqs[i]),
            .head_flit(heads[i]),
            .route_granted(route_grant.granted[i]),
            .route_outport(route_grant.outport),
            .switch_grant(switch_grant[i]),
            .xbar_ren(xbar_ren[i]),
            .xbar_flit(xbar_flits[i])
        );
    end

    switch_unit switch (
        .CLK(CLK),
        .nRST(nRST),
        .reqs(reqs),
        .xbar_flits(xbar_flits),
        .switch_grant(switch_grant),
        .xbar_ren(xbar_ren),
        .out_valid(out_valid),
        .out_flit(out_flit)
    );
endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic CLK,
    output logic nRST
);
    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;  // 10 ns period.
    end

    initial begin
        nRST = 1'b0;
        repeat (10) @(posedge CLK);
        #1 nRST = 1'b1;  // Release clear of the edge.
    end
endmodule

// ==== bench/router_assert.sv ====
`timescale 1ns/1ps

`include "router_defs.svh"

module router_assert (
    input logic                                CLK,
    input logic                                nRST,
    input logic              [`NUM_PORTS-1:0]  in_wen,
    input logic              [`NUM_PORTS-1:0]  in_full,
    input logic              [`NUM_PORTS-1:0]  out_valid,
    input router_pkg::flit_t [`NUM_PORTS-1:0]  out_flit
);
    int unsigned fail_count = 0;

    // Outputs stay quiet in reset and on the first cycle after it.
    a_reset_quiet: assert property (@(posedge CLK)
        (!nRST || $rose(nRST)) |-> (out_valid == '0 && in_full == '0))
        else begin
            fail_count++;
            $error("out_valid or in_full set around reset");
        end

    // ========================================
    // Per-port checks
    // ========================================
    for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port
        a_full_respected: assert property (@(posedge CLK) disable iff (!nRST)
            in_full[p] |-> !in_wen[p])
            else begin
                fail_count++;
                $error("write into full input port %0d", p);
            end

        a_full_after_write: assert property (@(posedge CLK) disable iff (!nRST)
            $rose(in_full[p]) |-> $past(in_wen[p]))
            else begin
                fail_count++;
                $error("in_full rose on port %0d without a write", p);
            end

        // Packets carry two flits or more.
        a_head_not_tail: assert property (@(posedge CLK) disable iff (!nRST)
            (out_valid[p] && out_flit[p].head) |-> !out_flit[p].tail)
            else begin
                fail_count++;
                $error("head flit with tail bit on output %0d", p);
            end
    end
endmodule

bind router_top router_assert ports_chk (
    .CLK(CLK),
    .nRST(nRST),
    .in_wen(in_wen),
    .in_full(in_full),
    .out_valid(out_valid),
    .out_flit(out_flit)
);

// ==== bench/router_tb.sv ====
`timescale 1ns/1ps

`include "router_defs.svh"

module router_tb;
    logic CLK;
    logic nRST;
    logic [`NUM_PORTS-1:0] in_wen;
    logic [`NUM_PORTS-1:0] in_full;
    logic [`NUM_PORTS-1:0] out_valid;
    router_pkg::flit_t [`NUM_PORTS-1:0] in_flit;
    router_pkg::flit_t [`NUM_PORTS-1:0] out_flit;

    router_pkg::flit_t pend [`NUM_PORTS][$];  // Flits waiting per source.
    router_pkg::flit_t sent_heads [`NUM_PORTS][$];  // Heads in write order per source.
    logic [31:0] rng;
    int cycle = 0;
    int flits_in = 0;
    int flits_out = 0;
    int first_write_cycle = 0;
    logic saw_full = 1'b0;

    // Expected state per output.
    logic [`NUM_PORTS-1:0] busy = '0;
    int head_cycle [`NUM_PORTS];
    int remain [`NUM_PORTS];
    int next_seq [`NUM_PORTS];
    logic [3:0] cur_src [`NUM_PORTS];
    logic [11:0] cur_tag [`NUM_PORTS];

    clock_gen clk_rst (
        .CLK(CLK),
        .nRST(nRST)
    );

    router_top UUT (
        .CLK(CLK),
        .nRST(nRST),
        .in_wen(in_wen),
        .in_flit(in_flit),
        .in_full(in_full),
        .out_valid(out_valid),
        .out_flit(out_flit)
    );

    always @(posedge CLK) begin
        cycle <= cycle + 1;
    end

    task automatic stop_failed();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
        stop_failed();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // X first, then Y.
    function automatic int xy_port(input logic [1:0] dx, input logic [1:0] dy);
        if (int'(dx) > `ROUTER_X) return `PORT_EAST;
        if (int'(dx) < `ROUTER_X) return `PORT_WEST;
        if (int'(dy) > `ROUTER_Y) return `PORT_NORTH;
        if (int'(dy) < `ROUTER_Y) return `PORT_SOUTH;
        return `PORT_LOCAL;
    endfunction

    // ========================================
    // Stimulus
    // ========================================
    task automatic queue_packet(input int src, input int dx, input int dy, input int len);
        router_pkg::flit_t f;
        logic [11:0] tag;
        rng = xorshift32(rng);
        tag = rng[11:0];
        f = '0;
        f.head = 1'b1;
        f.payload.head.dest_x  = 2'(dx);
        f.payload.head.dest_y  = 2'(dy);
        f.payload.head.pkt_len = 4'(len);
        f.payload.head.spare   = {4'(src), tag, 8'h00};
        sent_heads[src].push_back(f);
        pend[src].push_back(f);
        for (int s = 1; s < len; s++) begin
            f = '0;
            f.tail = (s == len - 1);
            f.payload.data = {4'(src), tag, 16'(s)};  // Source, tag, sequence.
            pend[src].push_back(f);
        end
    endtask

    task automatic send_all();
        int guard;
        logic more;
        guard = 0;
        more = 1'b1;
        while (more) begin
            @(posedge CLK);
            #1;
            more = 1'b0;
            for (int p = 0; p < `NUM_PORTS; p++) begin
                in_wen[p] = 1'b0;
                if (in_full[p]) saw_full = 1'b1;
                if (pend[p].size() != 0 && !in_full[p]) begin
                    if (flits_in == 0) first_write_cycle = cycle;
                    in_wen[p]  = 1'b1;
                    in_flit[p] = pend[p].pop_front();
                    flits_in++;
                end
                if (pend[p].size() != 0) more = 1'b1;
            end
            guard++;
            if (guard > 2000) begin
                $display("Timeout while writing flits into the router");
                stop_failed();
            end
        end
        @(posedge CLK);
        #1;
        in_wen = '0;
    endtask

    task automatic wait_drained();
        int guard;
        guard = 0;
        while (flits_out != flits_in || busy != '0) begin
            @(posedge CLK);
            guard++;
            if (guard > 1000) begin
                $display("Timeout: %0d flits written, %0d delivered", flits_in, flits_out);
                stop_failed();
            end
        end
    endtask

    // ========================================
    // Output monitor
    // ========================================
    always @(negedge CLK) begin
        router_pkg::flit_t f;
        router_pkg::flit_t exp_head;
        logic [31:0] exp_data;
        int src;
        if (UUT.ports_chk.fail_count != 0) begin
            $display("A bound assertion on the router ports failed");
            stop_failed();
        end
        for (int o = 0; o < `NUM_PORTS; o++) begin
            if (nRST && out_valid[o]) begin
                f = out_flit[o];
                flits_out++;
                if (f.head) begin
                    assert (!busy[o]) else report_mismatch("packet_length", 0, 32'(remain[o]));
                    // Match against the oldest undelivered head of each source.
                    src = -1;
                    for (int s = 0; s < `NUM_PORTS; s++) begin
                        if (src < 0 && sent_heads[s].size() != 0 && sent_heads[s][0] == f) begin
                            src = s;
                        end
                    end
                    assert (src >= 0) else begin
                        $display("Head flit on output %0d matches no packet that was sent", o);
                        stop_failed();
                    end
                    exp_head = sent_heads[src].pop_front();
                    assert (o == xy_port(exp_head.payload.head.dest_x,
                                         exp_head.payload.head.dest_y))
                        else report_mismatch("xy_route",
                            xy_port(exp_head.payload.head.dest_x,
                                    exp_head.payload.head.dest_y), o);
                    head_cycle[o] = cycle;
                    busy[o]       = 1'b1;
                    remain[o]     = int'(exp_head.payload.head.pkt_len) - 1;
                    next_seq[o]   = 1;
                    cur_src[o]    = 4'(src);
                    cur_tag[o]    = exp_head.payload.head.spare[19:8];
                end else begin
                    assert (busy[o]) else begin
                        $display("Body flit on output %0d outside any packet", o);
                        stop_failed();
                    end
                    exp_data = {cur_src[o], cur_tag[o], 16'(next_seq[o])};
                    assert (f.payload.data == exp_data)
                        else report_mismatch("body_order", exp_data, f.payload.data);
                    assert (f.tail == (remain[o] == 1))
                        else report_mismatch("tail_bit", 32'(remain[o] == 1), 32'(f.tail));
                    remain[o]   = remain[o] - 1;
                    next_seq[o] = next_seq[o] + 1;
                    if (remain[o] == 0) busy[o] = 1'b0;
                end
            end
        end
    end

    initial begin
        int guard;
        in_wen  = '0;
        in_flit = '0;
        rng     = 32'd80519;
        guard   = 0;
        while (!nRST) begin
            @(posedge CLK);
            guard++;
            if (guard > 50) begin
                $display("Timeout: reset was never released");
                stop_failed();
            end
        end

        // Lone packet through an idle router.
        queue_packet(`PORT_LOCAL, 3, 1, 3);
        send_all();
        wait_drained();
        assert (head_cycle[`PORT_EAST] - first_write_cycle == 4)
            else report_mismatch("head_latency", 4, head_cycle[`PORT_EAST] - first_write_cycle);

        // Mixed traffic from all inputs.
        for (int r = 0; r < 8; r++) begin
            for (int s = 0; s < `NUM_PORTS; s++) begin
                rng = xorshift32(rng);
                queue_packet(s, rng[1:0], rng[3:2], 2 + rng[5:4]);
            end
        end
        send_all();
        wait_drained();

        // Hotspot on the local output, FIFOs fill up.
        for (int s = 0; s < `NUM_PORTS; s++) begin
            queue_packet(s, `ROUTER_X, `ROUTER_Y, 5);
            queue_packet(s, `ROUTER_X, `ROUTER_Y, 5);
        end
        send_all();
        wait_drained();
        assert (saw_full) else begin
            $display("No input FIFO ever reported full");
            stop_failed();
        end

        repeat (5) @(posedge CLK);
        assert (flits_out == flits_in) else report_mismatch("flit_count", flits_in, flits_out);
        if (UUT.ports_chk.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("A bound assertion on the router ports failed");
            stop_failed();
        end
    end
endmodule

// ==== all.f ====
+incdir+include
hw/router_pkg.sv
hw/flit_fifo.sv
hw/input_unit.sv
hw/route_unit.sv
hw/switch_unit.sv
hw/router_top.sv
bench/clock_gen.sv
bench/router_assert.sv
bench/router_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the router testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module router_tb -o router_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Bound assertion errors must not stop the run before the testbench reports.
./obj_dir/router_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "Simulation PASSED"
exit 0
